// ==== cache_pkg.sv ====
/*
 * Shared types and constants for the data cache subsystem.
 * Imported by the RTL modules and by the testbench.
 */
package cache_pkg;

    // width of one data or address word.
    localparam int unsigned WORD_BITS = 32;

    // byte count of a word, and the byte-offset field it implies.
    localparam int unsigned WORD_BYTES = 4;
    localparam int unsigned BYTE_OFFSET_BITS = $clog2(WORD_BYTES);

    typedef logic [WORD_BITS-1:0] word_t;

    // processor request, held as a level until the cache lowers its miss.
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } cpu_req_t;

    // single-word request from the transfer glue to the RAM.
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } ram_req_t;

    // the address is split as tag, index, word offset and byte offset.
    // the byte offset is fixed here, the other fields follow the
    // BLOCKS and LINES parameters of the controller.

endpackage

// ==== cache_controller.sv ====
/*
 * Direct-mapped write-back cache controller with tag, valid and dirty storage.
 * Serves hits at once and runs write-back and refill transfers on a miss.
 */
`timescale 1ns/10ps

module cache_controller import cache_pkg::*; #(
    parameter int BLOCKS = 4,
    parameter int LINES  = 8
) (
    input  logic                    clock,
    input  logic                    reset,

    input  cpu_req_t                cpu,
    output word_t                   cpu_rdata,
    output logic                    cpu_miss,

    output logic                    mem_req,
    output logic                    mem_we,
    output word_t                   mem_addr,
    output word_t [BLOCKS-1:0]      mem_write_block,
    input  word_t [BLOCKS-1:0]      mem_read_block,
    input  logic                    mem_miss
);

    localparam int OFFSET_W   = $clog2(BLOCKS);
    localparam int INDEX_W    = $clog2(LINES);
    localparam int LINE_OFS_W = OFFSET_W + BYTE_OFFSET_BITS;
    localparam int TAG_W      = WORD_BITS - INDEX_W - LINE_OFS_W;

    typedef enum logic [1:0] {
        lookup,
        write_back,
        gap,
        refill
    } state_t;

    state_t                 state;

    logic [OFFSET_W-1:0]    offset;
    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;

    // line storage. only valid and dirty carry reset.
    logic [TAG_W-1:0]       tag_mem [LINES];
    word_t [BLOCKS-1:0]     data_mem [LINES];
    logic [LINES-1:0]       valid;
    logic [LINES-1:0]       dirty;

    logic                   hit;
    logic                   fill_done;
    logic                   write_hit;

    assign offset = cpu.addr[BYTE_OFFSET_BITS +: OFFSET_W];
    assign index  = cpu.addr[LINE_OFS_W +: INDEX_W];
    assign tag    = cpu.addr[WORD_BITS-1 -: TAG_W];

    assign hit = valid[index] && (tag_mem[index] == tag);

    // a request only completes from lookup, so the miss stays up for
    // the whole write-back, gap and refill sequence.
    assign cpu_miss  = cpu.req && !((state == lookup) && hit);
    assign cpu_rdata = (cpu.req && !cpu_miss && !cpu.we) ? data_mem[index][offset] : '0;

    assign write_hit = cpu.req && cpu.we && !cpu_miss;
    assign fill_done = (state == refill) && !mem_miss;

    assign mem_req = (state == write_back) || (state == refill);
    assign mem_we  = (state == write_back);

    // the victim address is rebuilt from the stored tag, the refill
    // address comes from the request itself.
    always_comb begin
        if (state == write_back) begin
            mem_addr = {tag_mem[index], index, {LINE_OFS_W{1'b0}}};
        end else begin
            mem_addr = {tag, index, {LINE_OFS_W{1'b0}}};
        end
    end

    assign mem_write_block = data_mem[index];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= lookup;
        end else begin
            case (state)
                lookup: begin
                    if (cpu.req && !hit) begin
                        if (valid[index] && dirty[index]) begin
                            state <= write_back;
                        end else begin
                            state <= refill;
                        end
                    end
                end
                write_back: begin
                    if (!mem_miss) begin
                        state <= gap;
                    end
                end
                // one idle cycle lets the glue see mem_req drop.
                gap: begin
                    state <= refill;
                end
                refill: begin
                    if (!mem_miss) begin
                        state <= lookup;
                    end
                end
                default: begin
                    state <= lookup;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_done) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (write_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    // a refilled line is installed whole; a write hit replaces one word.
    always_ff @(posedge clock) begin
        if (fill_done) begin
            data_mem[index] <= mem_read_block;
            tag_mem[index]  <= tag;
        end else if (write_hit) begin
            data_mem[index][offset] <= cpu.wdata;
        end
    end

endmodule

// ==== block_transfer_glue.sv ====
/*
 * Turns a cache line transfer into consecutive single-word RAM accesses.
 * Read words are collected and presented as one line on the last word.
 */
`timescale 1ns/10ps

module block_transfer_glue import cache_pkg::*; #(
    parameter int BLOCKS = 4
) (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    mem_req,
    input  logic                    mem_we,
    input  word_t                   mem_addr,
    input  word_t [BLOCKS-1:0]      mem_write_block,
    output word_t [BLOCKS-1:0]      mem_read_block,
    output logic                    mem_miss,

    output ram_req_t                ram,
    input  word_t                   ram_rdata,
    input  logic                    ram_miss
);

    localparam int CNT_W = $clog2(BLOCKS);

    logic [CNT_W-1:0]       word_cnt;
    logic                   last_word;

    // holds the first BLOCKS-1 read words, the last one comes straight
    // from the RAM.
    word_t [BLOCKS-2:0]     read_buf;

    assign last_word = (word_cnt == CNT_W'(BLOCKS - 1));

    assign mem_miss = mem_req && (ram_miss || !last_word);

    assign mem_read_block = (mem_req && !mem_we && !mem_miss) ? {ram_rdata, read_buf} : '0;

    always_comb begin
        ram.req   = mem_req;
        ram.we    = mem_we;
        ram.addr  = mem_addr + word_t'(word_cnt) * WORD_BYTES;
        ram.wdata = (mem_req && mem_we) ? mem_write_block[word_cnt] : '0;
    end

    // the counter wraps to zero on the last accepted word, ready for
    // the next transfer.
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            word_cnt <= '0;
        end else if (ram.req && !ram_miss) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ram.req && !ram.we && !ram_miss && !last_word) begin
            read_buf[word_cnt] <= ram_rdata;
        end
    end

endmodule

// ==== ram_model.sv ====
/*
 * Word-addressed RAM model with a configurable per-word latency.
 * Words never written read back as their own byte address.
 */
`timescale 1ns/10ps

module ram_model import cache_pkg::*; #(
    parameter int RAM_LATENCY = 1,
    parameter int MEM_WORDS   = 256
) (
    input  logic        clock,
    input  logic        reset,
    input  ram_req_t    ram,
    output word_t       ram_rdata,
    output logic        ram_miss
);

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam int LAT_W  = $clog2(RAM_LATENCY + 2);

    word_t                  mem [MEM_WORDS];
    logic [MEM_WORDS-1:0]   written;

    logic [ADDR_W-1:0]      word_idx;
    logic [LAT_W-1:0]       lat_cnt;
    logic                   accept;

    assign word_idx = ram.addr[BYTE_OFFSET_BITS +: ADDR_W];

    // the first RAM_LATENCY cycles of every word access are stalled.
    assign ram_miss = ram.req && (lat_cnt < LAT_W'(RAM_LATENCY));
    assign accept   = ram.req && !ram_miss;

    always_comb begin
        if (accept && !ram.we) begin
            ram_rdata = written[word_idx] ? mem[word_idx] : ram.addr;
        end else begin
            ram_rdata = '0;
        end
    end

    // restarts after each accepted word, and while idle.
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            lat_cnt <= '0;
        end else if (accept || !ram.req) begin
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            written <= '0;
        end else if (accept && ram.we) begin
            written[word_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && ram.we) begin
            mem[word_idx] <= ram.wdata;
        end
    end

endmodule

// ==== cache_subsystem_top.sv ====
/*
 * Cache subsystem top level. Sets the geometry and latency parameters and
 * connects the cache controller, the transfer glue and the RAM model.
 */
`timescale 1ns/10ps

module cache_subsystem_top import cache_pkg::*; #(
    parameter int BLOCKS      = 4,
    parameter int LINES       = 8,
    parameter int RAM_LATENCY = 1,
    parameter int MEM_WORDS   = 256
) (
    input  logic        clock,
    input  logic        reset,
    input  cpu_req_t    cpu,
    output word_t       cpu_rdata,
    output logic        cpu_miss
);

    logic                   mem_req;
    logic                   mem_we;
    word_t                  mem_addr;
    word_t [BLOCKS-1:0]     mem_write_block;
    word_t [BLOCKS-1:0]     mem_read_block;
    logic                   mem_miss;

    ram_req_t               ram;
    word_t                  ram_rdata;
    logic                   ram_miss;

    cache_controller #(
        .BLOCKS (BLOCKS),
        .LINES  (LINES)
    ) u_controller (
        .clock           (clock),
        .reset           (reset),
        .cpu             (cpu),
        .cpu_rdata       (cpu_rdata),
        .cpu_miss        (cpu_miss),
        .mem_req         (mem_req),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_write_block (mem_write_block),
        .mem_read_block  (mem_read_block),
        .mem_miss        (mem_miss)
    );

    block_transfer_glue #(
        .BLOCKS (BLOCKS)
    ) u_glue (
        .clock           (clock),
        .reset           (reset),
        .mem_req         (mem_req),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_write_block (mem_write_block),
        .mem_read_block  (mem_read_block),
        .mem_miss        (mem_miss),
        .ram             (ram),
        .ram_rdata       (ram_rdata),
        .ram_miss        (ram_miss)
    );

    ram_model #(
        .RAM_LATENCY (RAM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_ram (
        .clock     (clock),
        .reset     (reset),
        .ram       (ram),
        .ram_rdata (ram_rdata),
        .ram_miss  (ram_miss)
    );

endmodule

// ==== cache_checker.sv ====
/*
 * Testbench monitor for the processor port of the cache subsystem.
 * Keeps a shadow memory of all completed writes and checks every completed read.
 */
`timescale 1ns/10ps

module cache_checker import cache_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clock,
    input  logic        reset,
    input  cpu_req_t    cpu,
    input  word_t       cpu_rdata,
    input  logic        cpu_miss,
    input  logic        exp_check,
    input  word_t       exp_rdata,
    input  logic        exp_hit,
    output int          error_count,
    output int          check_count
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    // an unwritten word reads as its own byte address.
    word_t                  shadow [MEM_WORDS];
    logic [MEM_WORDS-1:0]   written;

    always @(posedge clock) begin
        int                 errs;
        int                 checks;
        word_t              expected;
        logic [ADDR_W-1:0]  idx;

        errs   = 0;
        checks = 0;
        idx    = ADDR_W'(cpu.addr / WORD_BYTES);
        if (!reset) begin
            written <= '0;
        end else if (!cpu.req) begin
            checks = 1;
            if (cpu_miss !== 1'b0 || cpu_rdata !== '0) begin
                $display("error at %0t: idle port shows miss %b and rdata %h",
                         $time, cpu_miss, cpu_rdata);
                errs++;
            end
        end else if (cpu_miss) begin
            if (exp_hit) begin
                $display("error at %0t: access to %h missed where a hit was expected",
                         $time, cpu.addr);
                errs++;
            end
        end else if (cpu.we) begin
            shadow[idx]  <= cpu.wdata;
            written[idx] <= 1'b1;
        end else begin
            expected = written[idx] ? shadow[idx] : cpu.addr;
            checks   = 1;
            if (cpu_rdata !== expected) begin
                $display("error at %0t: read of %h returned %h, shadow memory holds %h",
                         $time, cpu.addr, cpu_rdata, expected);
                errs++;
            end
            if (exp_check && cpu_rdata !== exp_rdata) begin
                $display("error at %0t: read of %h returned %h, table expects %h",
                         $time, cpu.addr, cpu_rdata, exp_rdata);
                errs++;
            end
        end
        error_count <= error_count + errs;
        check_count <= check_count + checks;
    end

endmodule

// ==== tb_cache.sv ====
/*
 * Testbench for the cache subsystem. Runs a directed table of accesses and
 * then a random phase, with cache_checker comparing every completed read.
 */
`timescale 1ns/10ps

module tb_cache import cache_pkg::*; ();

    localparam int BLOCKS         = 4;
    localparam int LINES          = 8;
    localparam int RAM_LATENCY    = 1;
    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 500;
    localparam int RANDOM_OPS     = 200;
    localparam int NUM_OPS        = 13;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
        logic  hit;
        word_t rdata;
    } op_t;

    logic       clock;
    logic       reset;
    cpu_req_t   cpu;
    word_t      cpu_rdata;
    logic       cpu_miss;
    logic       exp_check;
    logic       exp_hit;
    word_t      exp_rdata;
    int         error_count;
    int         check_count;

    op_t        ops [NUM_OPS];
    int         timeouts;
    int         tests_run;
    int         tests_failed;
    int         err_mark;
    int         timeout_mark;
    logic [31:0] rnd_state;

    cache_subsystem_top #(
        .BLOCKS      (BLOCKS),
        .LINES       (LINES),
        .RAM_LATENCY (RAM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .cpu       (cpu),
        .cpu_rdata (cpu_rdata),
        .cpu_miss  (cpu_miss)
    );

    cache_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clock       (clock),
        .reset       (reset),
        .cpu         (cpu),
        .cpu_rdata   (cpu_rdata),
        .cpu_miss    (cpu_miss),
        .exp_check   (exp_check),
        .exp_rdata   (exp_rdata),
        .exp_hit     (exp_hit),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    function automatic op_t make_op(logic we, word_t addr, word_t wdata, logic hit,
                                    word_t rdata);
        op_t op;
        op.we    = we;
        op.addr  = addr;
        op.wdata = wdata;
        op.hit   = hit;
        op.rdata = rdata;
        return op;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // called right after a rising edge; returns at the edge where the access completes.
    task automatic run_op(op_t op, logic check);
        int cycles;
        cpu       <= '{req: 1'b1, we: op.we, addr: op.addr, wdata: op.wdata};
        exp_check <= check && !op.we;
        exp_hit   <= check && op.hit;
        exp_rdata <= op.rdata;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
        end while (cpu_miss && cycles < TIMEOUT_CYCLES);
        if (cpu_miss) begin
            $display("timeout: access to %h still waiting after %0d cycles", op.addr, cycles);
            timeouts++;
        end
    endtask

    task automatic run_range(int first, int last);
        for (int i = first; i < last; i++) begin
            run_op(ops[i], 1'b1);
        end
    endtask

    task automatic go_idle();
        cpu       <= '0;
        exp_check <= 1'b0;
        exp_hit   <= 1'b0;
        exp_rdata <= '0;
        @(posedge clock);
    endtask

    task automatic start_test();
        err_mark     = error_count;
        timeout_mark = timeouts;
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (error_count != err_mark || timeouts != timeout_mark) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
    endtask

    initial begin
        op_t         op;
        word_t       addr;
        logic        we;

        cpu          = '0;
        exp_check    = 1'b0;
        exp_hit      = 1'b0;
        exp_rdata    = '0;
        reset        = 1'b0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;
        rnd_state    = 32'he5;

        // line 4 holds 0x40..0x4c; 0xc0..0xcc maps to the same line.
        ops[0]  = make_op(1'b0, 32'h40, '0, 1'b0, 32'h40);
        ops[1]  = make_op(1'b0, 32'h40, '0, 1'b1, 32'h40);
        ops[2]  = make_op(1'b0, 32'h44, '0, 1'b1, 32'h44);
        ops[3]  = make_op(1'b0, 32'h48, '0, 1'b1, 32'h48);
        ops[4]  = make_op(1'b0, 32'h4c, '0, 1'b1, 32'h4c);
        ops[5]  = make_op(1'b1, 32'h44, 32'hcafe0001, 1'b1, '0);
        ops[6]  = make_op(1'b0, 32'h44, '0, 1'b1, 32'hcafe0001);
        ops[7]  = make_op(1'b0, 32'h40, '0, 1'b1, 32'h40);
        ops[8]  = make_op(1'b0, 32'h48, '0, 1'b1, 32'h48);
        ops[9]  = make_op(1'b0, 32'hc4, '0, 1'b0, 32'hc4);
        ops[10] = make_op(1'b0, 32'hcc, '0, 1'b1, 32'hcc);
        ops[11] = make_op(1'b0, 32'h44, '0, 1'b0, 32'hcafe0001);
        ops[12] = make_op(1'b0, 32'h4c, '0, 1'b1, 32'h4c);

        repeat (2) @(posedge clock);
        reset <= 1'b1;

        start_test();
        repeat (4) @(posedge clock);
        report_test("idle after reset");

        start_test();
        run_range(0, 5);
        go_idle();
        report_test("cold read miss and line hits");

        start_test();
        run_range(5, 9);
        go_idle();
        report_test("write hit and read back");

        start_test();
        run_range(9, 13);
        go_idle();
        report_test("dirty eviction and refill");

        start_test();
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd_state = xorshift32(rnd_state);
            addr      = (rnd_state % MEM_WORDS) * WORD_BYTES;
            rnd_state = xorshift32(rnd_state);
            we        = rnd_state[0];
            rnd_state = xorshift32(rnd_state);
            op        = make_op(we, addr, rnd_state, 1'b0, '0);
            run_op(op, 1'b0);
        end
        go_idle();
        report_test("random mixed accesses");

        // the checker counts the idle cycle that ends at this edge a moment later.
        @(negedge clock);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
                 tests_run, tests_failed, check_count, error_count, timeouts);
        if (tests_failed == 0 && error_count == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
cache_pkg.sv
cache_controller.sv
block_transfer_glue.sv
ram_model.sv
cache_subsystem_top.sv
cache_checker.sv
tb_cache.sv

// ==== Makefile ====
# Verilator build and run for the cache subsystem testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_cache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides the result, whatever the simulator exit status is.
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
